/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Major opcodes in instruction bits 15:12
    typedef enum logic [3:0] {
        ALU0       = 4'd0,
        ALU1       = 4'd1,
        COMPLEX    = 4'd2,
        MEMORY     = 4'd3,
        JAL_REG    = 4'd8,
        JAL_IMM    = 4'd9,
        BRANCH_REG = 4'd10,
        BRANCH_IMM = 4'd11,
        IMM_LOW    = 4'd12,
        IMM_MID    = 4'd13,
        UPPER_IMM  = 4'd14,
        IMM_NEG    = 4'd15
    } opcodeT;

    // Instruction word, MSB first
    typedef struct packed {
        opcodeT     opcode;
        logic [3:0] regA;
        logic [3:0] minor;
        logic [3:0] regB;
    } instrT;

    // One-hot functional-unit enable
    typedef logic [4:0] fuEnableT;

    localparam fuEnableT FuNone    = 5'b00000;
    localparam fuEnableT FuAlu0    = 5'b00001;
    localparam fuEnableT FuAlu1    = 5'b00010;
    localparam fuEnableT FuComplex = 5'b00100;
    localparam fuEnableT FuMemory  = 5'b01000;
    localparam fuEnableT FuBranch  = 5'b10000;

    // Writeback source select
    typedef enum logic [1:0] {
        WB_RESERVED    = 2'b00,
        WB_PC_PLUS_ONE = 2'b01,
        WB_ALU0_IMM    = 2'b10,
        WB_ALU1        = 2'b11
    } wbSourceT;

    // Minor opcode forced onto every immediate instruction
    localparam logic [3:0] ImmMinorOpcode = 4'd7;
    localparam logic [3:0] LinkRegister   = 4'd15;

endpackage

`default_nettype wire

/* hw/decodePkg.sv */
`default_nettype none

package decodePkg;

    // Register file geometry
    localparam int RegCount = 16;

    typedef logic [$clog2(RegCount)-1:0] regAddrT;

    // Hardwired zero register
    localparam regAddrT ZeroReg = '0;

    // Control fields handed from the decoder to dispatch
    typedef struct packed {
        logic             tagRequest;
        isaPkg::fuEnableT fuEnable;
        isaPkg::wbSourceT wbSource;
        logic [3:0]       minorOpcode;

        logic             immediateEn;
        logic             upperImmediateEn;

        logic             regAReadEn;
        logic             regAWriteEn;
        regAddrT          regAAddr;

        logic             regBReadEn;
        regAddrT          regBAddr;

        // Flow control
        logic             branchStall;
        logic             jumpEn;
        logic             jumpAndLinkEn;
    } decodeCtrlT;

endpackage

`default_nettype wire

/* hw/regReadIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface regReadIf #(
    parameter int DataWidth = 16
);

    decodePkg::regAddrT   regAAddr;
    logic                 regAReadEn;
    decodePkg::regAddrT   regBAddr;
    logic                 regBReadEn;

    // Zero when the matching read enable is low
    logic [DataWidth-1:0] regAData;
    logic [DataWidth-1:0] regBData;

    modport decoder (
        output regAAddr, regAReadEn, regBAddr, regBReadEn,
        input  regAData, regBData
    );

    modport regFile (
        input  regAAddr, regAReadEn, regBAddr, regBReadEn,
        output regAData, regBData
    );

endinterface

`default_nettype wire

/* hw/reqAckSlot.sv */
`timescale 1ns/1ns
`default_nettype none

module reqAckSlot #(
    parameter type PayloadT = logic [15:0]
) (
    input  logic    clk,
    input  logic    rstN,

    // Four-phase sink
    input  logic    upReq,
    output logic    upAck,
    input  PayloadT upData,

    // Four-phase source
    output logic    downReq,
    input  logic    downAck,
    output PayloadT downData
);

    typedef enum logic [1:0] {
        SlotEmpty,
        SlotFull,
        SlotHanded
    } slotStateT;

    slotStateT state;
    logic      capture;

    // New word only once the previous upstream ack has dropped
    assign capture = (state == SlotEmpty) && upReq && !upAck;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            upAck <= 1'b0;
        end else if (capture) begin
            upAck <= 1'b1;
        end else if (!upReq) begin
            upAck <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= SlotEmpty;
            downReq <= 1'b0;
        end else begin
            case (state)
                SlotEmpty: begin
                    if (capture) begin
                        state <= SlotFull;
                    end
                end
                SlotFull: begin
                    // Req goes up the cycle after capture
                    if (!downReq) begin
                        downReq <= 1'b1;
                    end else if (downAck) begin
                        downReq <= 1'b0;
                        state   <= SlotHanded;
                    end
                end
                SlotHanded: begin
                    // Wait for the sink to finish its half
                    if (!downAck) begin
                        state <= SlotEmpty;
                    end
                end
                default: begin
                    state <= SlotEmpty;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            downData <= upData;
        end
    end

    payloadStable: assert property (@(posedge clk) disable iff (!rstN)
        downReq |=> (!downReq || $stable(downData)))
        else $error("reqAckSlot payload changed while downReq high");

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(upAck) |-> $past(upReq))
        else $error("reqAckSlot raised upAck without upReq");

endmodule

`default_nettype wire

/* hw/InstructionDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module InstructionDecoder #(
    parameter int DataWidth = 16
) (
    input  isaPkg::instrT         instr,
    output decodePkg::decodeCtrlT ctrl,
    output logic [DataWidth-1:0]  immediate,
    regReadIf.decoder             regRead
);

    decodePkg::regAddrT regAAddr;
    logic               isJumpLink;
    logic               isFlow;
    logic               upperAddrEn;
    logic               flowStall;
    logic               isListed;

    assign isJumpLink  = (instr.opcode == isaPkg::JAL_REG) || (instr.opcode == isaPkg::JAL_IMM);
    assign isFlow      = instr.opcode[3] && !instr.opcode[2];
    assign upperAddrEn = instr.opcode[3] && instr.opcode[0];

    // Opcodes 4 to 7 are unused and decode to nothing
    assign isListed    = instr.opcode[3] || !instr.opcode[2];

    // Register A address, link register wins over the aligned form
    always_comb begin
        if (isJumpLink) begin
            regAAddr = isaPkg::LinkRegister;
        end else if (upperAddrEn) begin
            regAAddr = {instr.regA[3:2], 2'b00};
        end else begin
            regAAddr = instr.regA;
        end
    end

    // Only meaningful for the four flow opcodes
    assign flowStall = (regAAddr != decodePkg::ZeroReg);

    always_comb begin
        ctrl = '0;
        case (instr.opcode)
            isaPkg::ALU0, isaPkg::ALU1: begin
                ctrl.fuEnable    = instr.opcode[0] ? isaPkg::FuAlu1 : isaPkg::FuAlu0;
                ctrl.wbSource    = instr.opcode[0] ? isaPkg::WB_ALU1 : isaPkg::WB_ALU0_IMM;
                ctrl.regAReadEn  = 1'b1;
                ctrl.regAWriteEn = 1'b1;
                ctrl.regBReadEn  = 1'b1;
            end
            isaPkg::COMPLEX, isaPkg::MEMORY: begin
                // Long-latency units need a result tag
                ctrl.tagRequest = 1'b1;
                ctrl.fuEnable   = instr.opcode[0] ? isaPkg::FuMemory : isaPkg::FuComplex;
                ctrl.regAReadEn = 1'b1;
                ctrl.regBReadEn = 1'b1;
            end
            isaPkg::JAL_REG, isaPkg::JAL_IMM, isaPkg::BRANCH_REG, isaPkg::BRANCH_IMM: begin
                ctrl.tagRequest  = flowStall;
                ctrl.fuEnable    = flowStall ? isaPkg::FuBranch : isaPkg::FuNone;
                ctrl.wbSource    = isJumpLink ? isaPkg::WB_PC_PLUS_ONE : isaPkg::WB_RESERVED;
                ctrl.immediateEn = instr.opcode[0];
                ctrl.regAReadEn  = 1'b1;
                ctrl.regAWriteEn = isJumpLink;
                ctrl.branchStall = flowStall;
            end
            isaPkg::UPPER_IMM: begin
                ctrl.wbSource         = isaPkg::WB_ALU0_IMM;
                ctrl.immediateEn      = 1'b1;
                ctrl.upperImmediateEn = 1'b1;
                ctrl.regAReadEn       = 1'b1;
                ctrl.regAWriteEn      = 1'b1;
            end
            isaPkg::IMM_LOW, isaPkg::IMM_MID, isaPkg::IMM_NEG: begin
                ctrl.wbSource    = isaPkg::WB_ALU0_IMM;
                ctrl.immediateEn = 1'b1;
                ctrl.regAWriteEn = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase

        // Fields taken straight from the word
        if (isListed) begin
            ctrl.minorOpcode = ctrl.immediateEn ? isaPkg::ImmMinorOpcode : instr.minor;
            ctrl.regAAddr    = regAAddr;
            ctrl.regBAddr    = instr.regB;
        end

        ctrl.jumpEn        = isFlow && !ctrl.branchStall;
        ctrl.jumpAndLinkEn = isJumpLink && !ctrl.branchStall;
    end

    // Immediate form picked by opcode bits 1:0
    always_comb begin
        case (instr.opcode[1:0])
            2'b01: begin
                immediate = DataWidth'({instr.regA[1:0], instr.minor, instr.regB});
            end
            2'b10: begin
                immediate = DataWidth'({instr.minor, instr.regB, 8'h00});
            end
            2'b11: begin
                // Negative form, upper bits all ones
                immediate       = '1;
                immediate[9:0]  = {instr.regA[1:0], instr.minor, instr.regB};
            end
            default: begin
                immediate = DataWidth'({instr.minor, instr.regB});
            end
        endcase
    end

    assign regRead.regAAddr   = ctrl.regAAddr;
    assign regRead.regAReadEn = ctrl.regAReadEn;
    assign regRead.regBAddr   = ctrl.regBAddr;
    assign regRead.regBReadEn = ctrl.regBReadEn;

    always_comb begin
        fuOneHot: assert final ($onehot0(ctrl.fuEnable))
            else $error("InstructionDecoder fuEnable not one-hot");
    end

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
    parameter int DataWidth = 16
) (
    input  logic                 clk,
    input  logic                 rstN,

    // Writeback port
    input  logic                 wbEn,
    input  decodePkg::regAddrT   wbAddr,
    input  logic [DataWidth-1:0] wbData,

    regReadIf.regFile            regRead
);

    logic [DataWidth-1:0] regs [decodePkg::RegCount];
    logic                 wbHit;

    // Writes to r0 are dropped so it stays zero
    assign wbHit = wbEn && (wbAddr != decodePkg::ZeroReg);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < decodePkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbHit) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Combinational reads, no bypass from a same-cycle write
    always_comb begin
        if (regRead.regAReadEn) begin
            regRead.regAData = regs[regRead.regAAddr];
        end else begin
            regRead.regAData = '0;
        end
    end

    always_comb begin
        if (regRead.regBReadEn) begin
            regRead.regBData = regs[regRead.regBAddr];
        end else begin
            regRead.regBData = '0;
        end
    end

    wbAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        wbEn |-> !$isunknown(wbAddr))
        else $error("registerFile wbAddr unknown during writeback");

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage #(
    parameter int DataWidth = 16
) (
    input  logic                  clk,
    input  logic                  rstN,

    // Instruction link
    input  logic                  inReq,
    output logic                  inAck,
    input  isaPkg::instrT         inInstr,

    // Dispatch link
    output logic                  outReq,
    input  logic                  outAck,
    output decodePkg::decodeCtrlT outCtrl,
    output logic [DataWidth-1:0]  outImmediate,
    output logic [DataWidth-1:0]  outRegAData,
    output logic [DataWidth-1:0]  outRegBData,

    // Writeback
    input  logic                  wbEn,
    input  decodePkg::regAddrT    wbAddr,
    input  logic [DataWidth-1:0]  wbData
);

    typedef struct packed {
        decodePkg::decodeCtrlT ctrl;
        logic [DataWidth-1:0]  immediate;
        logic [DataWidth-1:0]  regAData;
        logic [DataWidth-1:0]  regBData;
    } dispatchT;

    isaPkg::instrT         heldInstr;
    logic                  midReq;
    logic                  midAck;
    decodePkg::decodeCtrlT decodedCtrl;
    logic [DataWidth-1:0]  decodedImm;
    dispatchT              dispatchIn;
    dispatchT              dispatchOut;

    regReadIf #(.DataWidth(DataWidth)) regRead ();

    reqAckSlot #(.PayloadT(isaPkg::instrT)) inSlot (
        .clk      (clk),
        .rstN     (rstN),
        .upReq    (inReq),
        .upAck    (inAck),
        .upData   (inInstr),
        .downReq  (midReq),
        .downAck  (midAck),
        .downData (heldInstr)
    );

    InstructionDecoder #(.DataWidth(DataWidth)) i_InstructionDecoder (
        .instr     (heldInstr),
        .ctrl      (decodedCtrl),
        .immediate (decodedImm),
        .regRead   (regRead.decoder)
    );

    registerFile #(.DataWidth(DataWidth)) i_registerFile (
        .clk     (clk),
        .rstN    (rstN),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .regRead (regRead.regFile)
    );

    // Operands join the decoded fields on the way to the output slot
    assign dispatchIn = '{
        ctrl:      decodedCtrl,
        immediate: decodedImm,
        regAData:  regRead.regAData,
        regBData:  regRead.regBData
    };

    reqAckSlot #(.PayloadT(dispatchT)) outSlot (
        .clk      (clk),
        .rstN     (rstN),
        .upReq    (midReq),
        .upAck    (midAck),
        .upData   (dispatchIn),
        .downReq  (outReq),
        .downAck  (outAck),
        .downData (dispatchOut)
    );

    assign outCtrl      = dispatchOut.ctrl;
    assign outImmediate = dispatchOut.immediate;
    assign outRegAData  = dispatchOut.regAData;
    assign outRegBData  = dispatchOut.regBData;

endmodule

`default_nettype wire

/* verification/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected dispatch packet, field order of the output link
typedef struct packed {
    decodePkg::decodeCtrlT ctrl;
    logic [DataWidth-1:0]  immediate;
    logic [DataWidth-1:0]  regAData;
    logic [DataWidth-1:0]  regBData;
} expectT;

// Copy of the register file contents as seen by writebacks
logic [DataWidth-1:0] mirror [decodePkg::RegCount];

function automatic void mirrorWrite(decodePkg::regAddrT addr, logic [DataWidth-1:0] data);
    // r0 is hardwired to zero
    if (addr != '0) begin
        mirror[addr] = data;
    end
endfunction

function automatic logic [DataWidth-1:0] refImmediate(logic [15:0] word);
    logic [DataWidth-1:0] imm;
    imm = '0;
    case (word[13:12])
        2'b00: imm = DataWidth'(word[7:0]);
        2'b01: imm = DataWidth'(word[9:0]);
        2'b10: imm = DataWidth'(word[7:0]) << 8;
        default: begin
            imm = '1;
            imm[9:0] = word[9:0];
        end
    endcase
    return imm;
endfunction

function automatic decodePkg::decodeCtrlT refCtrl(logic [15:0] word);
    decodePkg::decodeCtrlT c;
    logic [3:0]            op;
    logic                  link;
    logic                  stall;
    op = word[15:12];
    c = '0;
    link = (op == isaPkg::JAL_REG) || (op == isaPkg::JAL_IMM);
    c.regAAddr = link ? isaPkg::LinkRegister :
                 (op[3] && op[0]) ? {word[11:10], 2'b00} : word[11:8];
    c.regBAddr = word[3:0];
    stall = (c.regAAddr != '0);
    case (op)
        isaPkg::ALU0, isaPkg::ALU1: begin
            c.fuEnable    = (op == isaPkg::ALU0) ? isaPkg::FuAlu0 : isaPkg::FuAlu1;
            c.wbSource    = (op == isaPkg::ALU0) ? isaPkg::WB_ALU0_IMM : isaPkg::WB_ALU1;
            c.regAReadEn  = 1'b1;
            c.regAWriteEn = 1'b1;
            c.regBReadEn  = 1'b1;
        end
        isaPkg::COMPLEX, isaPkg::MEMORY: begin
            c.tagRequest = 1'b1;
            c.fuEnable   = (op == isaPkg::COMPLEX) ? isaPkg::FuComplex : isaPkg::FuMemory;
            c.regAReadEn = 1'b1;
            c.regBReadEn = 1'b1;
        end
        isaPkg::JAL_REG, isaPkg::JAL_IMM, isaPkg::BRANCH_REG, isaPkg::BRANCH_IMM: begin
            c.tagRequest    = stall;
            c.fuEnable      = stall ? isaPkg::FuBranch : isaPkg::FuNone;
            c.wbSource      = link ? isaPkg::WB_PC_PLUS_ONE : isaPkg::WB_RESERVED;
            c.immediateEn   = (op == isaPkg::JAL_IMM) || (op == isaPkg::BRANCH_IMM);
            c.regAReadEn    = 1'b1;
            c.regAWriteEn   = link;
            c.branchStall   = stall;
            c.jumpEn        = !stall;
            c.jumpAndLinkEn = link && !stall;
        end
        isaPkg::UPPER_IMM: begin
            c.wbSource         = isaPkg::WB_ALU0_IMM;
            c.immediateEn      = 1'b1;
            c.upperImmediateEn = 1'b1;
            c.regAReadEn       = 1'b1;
            c.regAWriteEn      = 1'b1;
        end
        isaPkg::IMM_LOW, isaPkg::IMM_MID, isaPkg::IMM_NEG: begin
            c.wbSource    = isaPkg::WB_ALU0_IMM;
            c.immediateEn = 1'b1;
            c.regAWriteEn = 1'b1;
        end
        default: begin
            // Opcodes 4 to 7 decode to nothing at all
            return '0;
        end
    endcase
    c.minorOpcode = c.immediateEn ? isaPkg::ImmMinorOpcode : word[7:4];
    return c;
endfunction

function automatic expectT refPacket(logic [15:0] word);
    expectT p;
    p.ctrl      = refCtrl(word);
    p.immediate = refImmediate(word);
    p.regAData  = p.ctrl.regAReadEn ? mirror[p.ctrl.regAAddr] : '0;
    p.regBData  = p.ctrl.regBReadEn ? mirror[p.ctrl.regBAddr] : '0;
    return p;
endfunction

`endif

/* verification/decodeStageTb.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb;

    localparam int DataWidth      = 16;
    localparam int ClkPeriod      = 10;
    localparam int ResetCycles    = 16;
    localparam int NumBatches     = 8;
    localparam int BatchSize      = 24;
    localparam int WritesPerBatch = 8;
    localparam int DirectedCount  = 28;
    localparam int TailCycles     = 20;
    localparam int NumInstr       = DirectedCount + (NumBatches - 1) * BatchSize;
    // 40 cycles per instruction plus reset, writeback and tail phases
    localparam int TimeoutCycles  = NumInstr * 40 + ResetCycles + TailCycles
                                    + NumBatches * (WritesPerBatch + 1);
    // Register A fields for flow opcodes, zero, aligned-to-zero and stalling
    localparam logic [3:0] FlowRegA [3] = '{4'h0, 4'h3, 4'hC};

    logic                  clk;
    logic                  rstN;
    logic                  inReq;
    logic                  inAck;
    isaPkg::instrT         inInstr;
    logic                  outReq;
    logic                  outAck;
    decodePkg::decodeCtrlT outCtrl;
    logic [DataWidth-1:0]  outImmediate;
    logic [DataWidth-1:0]  outRegAData;
    logic [DataWidth-1:0]  outRegBData;
    logic                  wbEn;
    decodePkg::regAddrT    wbAddr;
    logic [DataWidth-1:0]  wbData;

    integer seed;
    int     sentCount;
    int     recvCount;
    logic   reqAtEdge;
    logic   lastAck;

    `include "decodeModel.svh"

    expectT expQ[$];

    decodeStage #(.DataWidth(DataWidth)) i_decodeStage (
        .clk          (clk),
        .rstN         (rstN),
        .inReq        (inReq),
        .inAck        (inAck),
        .inInstr      (inInstr),
        .outReq       (outReq),
        .outAck       (outAck),
        .outCtrl      (outCtrl),
        .outImmediate (outImmediate),
        .outRegAData  (outRegAData),
        .outRegBData  (outRegBData),
        .wbEn         (wbEn),
        .wbAddr       (wbAddr),
        .wbData       (wbData)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkCtrl(string name, decodePkg::decodeCtrlT got,
                             decodePkg::decodeCtrlT exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkData(string name, logic [DataWidth-1:0] got, logic [DataWidth-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkIdle(string when);
        if (inAck !== 1'b0 || outReq !== 1'b0) begin
            failRun($sformatf("inAck or outReq not low %s at %0t", when, $time));
        end
    endtask

    task automatic writeRegs(int count);
        decodePkg::regAddrT   addr;
        logic [DataWidth-1:0] data;
        repeat (count) begin
            @(negedge clk);
            addr   = 4'($random(seed));
            data   = DataWidth'($random(seed));
            wbEn   = 1'b1;
            wbAddr = addr;
            wbData = data;
            mirrorWrite(addr, data);
        end
        @(negedge clk);
        wbEn = 1'b0;
    endtask

    // Four-phase source, one word per call
    task automatic sendInstr(logic [15:0] word);
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        @(negedge clk);
        inInstr = isaPkg::instrT'(word);
        inReq   = 1'b1;
        expQ.push_back(refPacket(word));
        sentCount++;
        @(negedge clk);
        while (inAck !== 1'b1) begin
            @(negedge clk);
        end
        inReq = 1'b0;
        @(negedge clk);
        while (inAck !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin : stimulus
        logic [15:0] word;
        clk       = 1'b0;
        rstN      = 1'b0;
        inReq     = 1'b0;
        inInstr   = '0;
        outAck    = 1'b0;
        wbEn      = 1'b0;
        wbAddr    = '0;
        wbData    = '0;
        seed      = 32'hd8f1_dbf8;
        sentCount = 0;
        recvCount = 0;
        reqAtEdge = 1'b0;
        lastAck   = 1'b0;
        for (int i = 0; i < decodePkg::RegCount; i++) begin
            mirror[i] = '0;
        end
        repeat (ResetCycles) begin
            @(negedge clk);
            checkIdle("during reset");
        end
        rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkIdle("just after reset");
        end

        // Every opcode once, then flow opcodes over chosen register A fields
        writeRegs(WritesPerBatch);
        for (int op = 0; op < 16; op++) begin
            word = 16'($random(seed));
            word[15:12] = 4'(op);
            sendInstr(word);
        end
        for (int op = 8; op < 12; op++) begin
            for (int k = 0; k < 3; k++) begin
                word = 16'($random(seed));
                word[15:12] = 4'(op);
                word[11:8] = FlowRegA[k];
                sendInstr(word);
            end
        end
        drain();

        for (int b = 1; b < NumBatches; b++) begin
            writeRegs(WritesPerBatch);
            repeat (BatchSize) begin
                sendInstr(16'($random(seed)));
            end
            drain();
        end

        // Idle tail so a duplicated packet still reaches the sink
        repeat (TailCycles) @(negedge clk);

        if (recvCount != NumInstr) begin
            failRun($sformatf("expected %0d packets but received %0d", NumInstr, recvCount));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Sink with random ack delays, compares each packet in arrival order
    initial begin : sink
        expectT exp;
        forever begin
            @(negedge clk);
            if (outReq === 1'b1) begin
                if (expQ.size() == 0) begin
                    failRun("outReq raised with no instruction outstanding");
                end
                exp = expQ.pop_front();
                checkCtrl("outCtrl", outCtrl, exp.ctrl);
                checkData("outImmediate", outImmediate, exp.immediate);
                checkData("outRegAData", outRegAData, exp.regAData);
                checkData("outRegBData", outRegBData, exp.regBData);
                recvCount++;
                repeat ($unsigned($random(seed)) % 6) @(negedge clk);
                outAck = 1'b1;
                @(negedge clk);
                while (outReq !== 1'b0) begin
                    @(negedge clk);
                end
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                outAck = 1'b0;
            end
        end
    end

    // inAck may only rise on a high inReq and fall on a low one
    always @(posedge clk) begin
        reqAtEdge <= inReq;
    end

    always @(negedge clk) begin
        if (rstN) begin
            if (inAck && !lastAck && !reqAtEdge) begin
                failRun($sformatf("inAck rose while inReq was low at %0t", $time));
            end
            if (!inAck && lastAck && reqAtEdge) begin
                failRun($sformatf("inAck fell while inReq was still high at %0t", $time));
            end
        end
        lastAck = inAck;
    end

    initial begin : watchdog
        #(TimeoutCycles * ClkPeriod);
        failRun($sformatf("timeout after %0d cycles with %0d of %0d packets received",
                          TimeoutCycles, recvCount, NumInstr));
    end

endmodule

`default_nettype wire

/* decodeStage.f */
+incdir+verification
hw/isaPkg.sv
hw/decodePkg.sv
hw/regReadIf.sv
hw/reqAckSlot.sv
hw/InstructionDecoder.sv
hw/registerFile.sv
hw/decodeStage.sv
verification/decodeStageTb.sv

/* Makefile */
# Verilator flow for the decode stage

VERILATOR ?= verilator
TB_TOP    ?= decodeStageTb
RTL_TOP   ?= decodeStage
FILELIST  ?= decodeStage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
